/* Bender.yml */
package:
  name: mem_ram_sdp

sources:
  # RTL in compile order
  - files:
      - source/mem_pkg.sv
      - source/mem_init_fsm.sv
      - source/mem_ram_core.sv
      - source/mem_rd_port.sv
      - source/mem_ram_sdp.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/mem_ram_sdp_sva.sv
      - verification/tb_mem_ram_sdp.sv

/* all.f */
source/mem_pkg.sv
source/mem_init_fsm.sv
source/mem_ram_core.sv
source/mem_rd_port.sv
source/mem_ram_sdp.sv
verification/mem_ram_sdp_sva.sv
verification/tb_mem_ram_sdp.sv

/* source/mem_init_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_init_fsm
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // User write request
    input  mem_wr_req_t wr,
    // Write port of the storage core
    output mem_wr_req_t core_wr,
    // High once clearing is complete
    output logic        rdy
);

    // ==================================================
    // Types
    // ==================================================

    // CLEAR walks the array, RUN hands the port to the user
    typedef enum logic {
        ST_CLEAR = 1'b0,
        ST_RUN   = 1'b1
    } state_t;

    // ==================================================
    // Signals
    // ==================================================

    state_t state;
    state_t nxt_state;

    // Address of the entry being cleared
    addr_t  clr_addr;

    // Last entry is written on this cycle
    logic   clr_last;

    // ==================================================
    // Sequencer
    // ==================================================

    assign clr_last = (clr_addr == addr_t'(DEPTH-1));

    // Next state
    always_comb begin
        nxt_state = state;
        case (state)
            ST_CLEAR: if (clr_last) nxt_state = ST_RUN;
            ST_RUN:   nxt_state = ST_RUN;
            default:  nxt_state = ST_CLEAR;
        endcase
    end

    // State register, every reset restarts the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_CLEAR;
        end else begin
            state <= nxt_state;
        end
    end

    // Clear address counter
    // One entry per cycle, wraps back to zero after the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr <= '0;
        end else if (state == ST_CLEAR) begin
            clr_addr <= clr_addr + addr_t'(1);
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    // Straight from the state register
    assign rdy = (state == ST_RUN);

    // Write port mux
    // Clearing owns the port, afterwards the user request passes through
    // User writes during CLEAR are dropped here
    always_comb begin
        if (state == ST_CLEAR) begin
            core_wr.en   = 1'b1;
            core_wr.addr = clr_addr;
            core_wr.data = '0;
        end else begin
            core_wr = wr;
        end
    end

endmodule : mem_init_fsm

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ==================================================
    // Sizes
    // ==================================================

    // Address and data widths of the RAM
    localparam int ADDR_WID = 8;
    localparam int DATA_WID = 32;

    // One entry per address value
    localparam int DEPTH = 2**ADDR_WID;

    // Accepted read request to response, in clock cycles
    // Core register plus one output register
    localparam int RD_LATENCY = 2;

    // ==================================================
    // Base types
    // ==================================================

    typedef logic [ADDR_WID-1:0] addr_t;
    typedef logic [DATA_WID-1:0] data_t;

    // ==================================================
    // Port structs
    // ==================================================

    // Write request, one write per cycle while en is high
    // Also the format of the core's internal write port
    typedef struct packed {
        logic  en;
        addr_t addr;
        data_t data;
    } mem_wr_req_t;

    // Read request
    // Accepted on any edge where req and rdy are both high
    typedef struct packed {
        logic  req;
        addr_t addr;
    } mem_rd_req_t;

    // Read response
    // ack is a single-cycle strobe, data valid only with it
    typedef struct packed {
        logic  ack;
        data_t data;
    } mem_rd_resp_t;

endpackage : mem_pkg

`default_nettype wire

/* source/mem_ram_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ram_core
    import mem_pkg::*;
(
    input  logic        clk,
    // Write port, already arbitrated
    input  mem_wr_req_t wr,
    // Read port, address in and registered data out
    input  addr_t       rd_addr,
    output data_t       rd_data
);

    // ==================================================
    // Storage
    // ==================================================

    // DEPTH x DATA_WID array
    // Contents are defined by the clear sequence, not by reset
    data_t mem [DEPTH];

    // Registered read data
    data_t rd_data_q;

    // ==================================================
    // Write
    // ==================================================

    // Takes effect on the edge
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // ==================================================
    // Read
    // ==================================================

    // Array is sampled before the write of the same edge lands,
    // so a same-address collision returns the old word (read-first)
    always_ff @(posedge clk) begin
        rd_data_q <= mem[rd_addr];
    end

    // Data follows the address by one cycle
    assign rd_data = rd_data_q;

endmodule : mem_ram_core

`default_nettype wire

/* source/mem_ram_sdp.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ram_sdp
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // Write port
    input  mem_wr_req_t  wr,
    // Read port
    input  mem_rd_req_t  rd,
    output mem_rd_resp_t rd_resp,
    // High once the memory is cleared
    output logic         rdy
);

    // ==================================================
    // Internal wires
    // ==================================================

    // Arbitrated write port into the core
    mem_wr_req_t core_wr;

    // Core read port
    addr_t       core_rd_addr;
    data_t       core_rd_data;

    // ==================================================
    // Clear sequencer
    // ==================================================

    // Owns the core write port until rdy
    mem_init_fsm i_mem_init_fsm (
        .clk     ( clk ),
        .rst     ( rst ),
        .wr      ( wr ),
        .core_wr ( core_wr ),
        .rdy     ( rdy )
    );

    // ==================================================
    // Storage core
    // ==================================================

    mem_ram_core i_mem_ram_core (
        .clk     ( clk ),
        .wr      ( core_wr ),
        .rd_addr ( core_rd_addr ),
        .rd_data ( core_rd_data )
    );

    // ==================================================
    // Read pipeline
    // ==================================================

    // Adds the output stage, two cycles in total
    mem_rd_port i_mem_rd_port (
        .clk       ( clk ),
        .rst       ( rst ),
        .rd        ( rd ),
        .rdy       ( rdy ),
        .core_addr ( core_rd_addr ),
        .core_data ( core_rd_data ),
        .rd_resp   ( rd_resp )
    );

endmodule : mem_ram_sdp

`default_nettype wire

/* source/mem_rd_port.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_rd_port
    import mem_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    // User read request
    input  mem_rd_req_t  rd,
    // Clear done
    input  logic         rdy,
    // Core read port
    output addr_t        core_addr,
    input  data_t        core_data,
    // User read response
    output mem_rd_resp_t rd_resp
);

    // ==================================================
    // Signals
    // ==================================================

    // Request accepted on this edge
    logic                  rd_acc;

    // Valid chain, one bit per pipeline stage
    logic [RD_LATENCY-1:0] vld_sr;

    // Output data register
    data_t                 rd_data_q;

    // ==================================================
    // Request side
    // ==================================================

    // Nothing is accepted before clearing is done
    assign rd_acc = rd.req & rdy;

    // Address goes straight to the core register
    assign core_addr = rd.addr;

    // ==================================================
    // Valid chain
    // ==================================================

    // Reset discards any read in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[RD_LATENCY-2:0], rd_acc};
        end
    end

    // ==================================================
    // Data stage
    // ==================================================

    // Core data is valid one cycle after accept
    // Capture it only then, so the register holds between reads
    always_ff @(posedge clk) begin
        if (vld_sr[RD_LATENCY-2]) begin
            rd_data_q <= core_data;
        end
    end

    // ==================================================
    // Response
    // ==================================================

    // Ack lines up with the output data register
    assign rd_resp.ack  = vld_sr[RD_LATENCY-1];
    assign rd_resp.data = rd_data_q;

endmodule : mem_rd_port

`default_nettype wire

/* verification/mem_ram_sdp_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ram_sdp_sva
    import mem_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input mem_rd_req_t  rd,
    input mem_rd_resp_t rd_resp,
    input logic         rdy
);

    // ==================================================
    // Port protocol
    // ==================================================

    // Read accepted on this edge
    logic rd_acc;

    assign rd_acc = rd.req & rdy & ~rst;

    // Reset clears rdy and the ack strobe by the next cycle
    assert property (@(posedge clk) rst |=> (!rdy && !rd_resp.ack))
        else $error("rdy or ack still high in the cycle after reset");

    // Fixed latency, no dropped reads
    assert property (@(posedge clk) disable iff (rst) rd_acc |-> ##RD_LATENCY rd_resp.ack)
        else $error("accepted read was not acknowledged after the read latency");

    // No ack without a read that caused it
    assert property (@(posedge clk) disable iff (rst) rd_resp.ack |-> $past(rd_acc, RD_LATENCY))
        else $error("ack seen without an accepted read");

endmodule : mem_ram_sdp_sva

bind mem_ram_sdp mem_ram_sdp_sva i_mem_ram_sdp_sva (
    .clk     ( clk ),
    .rst     ( rst ),
    .rd      ( rd ),
    .rd_resp ( rd_resp ),
    .rdy     ( rdy )
);

`default_nettype wire

/* verification/tb_mem_ram_sdp.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_ram_sdp
    import mem_pkg::*;
();

    // ==================================================
    // Constants and types
    // ==================================================

    localparam int          CYCLE_LIMIT = 5000;
    localparam logic [31:0] SEED        = 32'd5;
    localparam int          RST_CYCLES  = 5;
    localparam int          BURST_LEN   = 64;
    localparam int          DROP_WR     = 8;

    // One outstanding read with its address for the error line
    typedef struct packed {
        addr_t addr;
        data_t data;
    } exp_t;

    // ==================================================
    // Signals and bookkeeping
    // ==================================================

    logic         clk;
    logic         rst;
    mem_wr_req_t  wr;
    mem_rd_req_t  rd;
    mem_rd_resp_t rd_resp;
    logic         rdy;

    // Shadow of the RAM contents
    data_t        shadow [DEPTH];
    // Expected words of accepted reads in issue order
    exp_t         exp_q [$];

    logic [31:0]  rng_state = SEED;
    int           cycle_cnt = 0;
    int           err_cnt   = 0;
    int           chk_cnt   = 0;
    int           test_cnt  = 0;
    int           test_err0 = 0;
    int           test_chk0 = 0;

    mem_ram_sdp UUT (
        .clk     ( clk ),
        .rst     ( rst ),
        .wr      ( wr ),
        .rd      ( rd ),
        .rd_resp ( rd_resp ),
        .rdy     ( rdy )
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function addr_t rand_addr();
        return addr_t'(rand_word());
    endfunction

    // Reference model returns the last word written while ready
    // Zero after a clear
    function data_t expected_word(input addr_t a);
        return shadow[a];
    endfunction

    // One cycle of stimulus for the DUT to sample on the next edge
    task automatic drive_cycle(input logic we, input addr_t wa, input data_t wd,
                               input logic re, input addr_t ra);
        @(posedge clk);
        wr <= '{en: we, addr: wa, data: wd};
        rd <= '{req: re, addr: ra};
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    // Cycles from the call until rdy is seen high
    task automatic wait_rdy(output int n);
        n = 0;
        @(negedge clk);
        while (!rdy) begin
            @(negedge clk);
            n++;
        end
    endtask

    // Give outstanding reads time to come back
    task automatic drain_reads();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < RD_LATENCY + 4) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d reads were accepted but never acknowledged", exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic start_test();
        test_err0 = err_cnt;
        test_chk0 = chk_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %0d %-24s finished: %0d checks, %0d errors",
                 test_cnt, name, chk_cnt - test_chk0, err_cnt - test_err0);
    endtask

    // ==================================================
    // Reference tracking and comparison
    // ==================================================

    // Accesses seen mid-cycle take effect on the next edge
    // Read is recorded before the write to match read-first
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                shadow[i] = '0;
            end
        end else if (rdy) begin
            if (rd.req) begin
                exp_q.push_back('{addr: rd.addr, data: expected_word(rd.addr)});
            end
            if (wr.en) begin
                shadow[wr.addr] = wr.data;
            end
        end
    end

    always @(negedge clk) begin : check_resp
        exp_t e;
        if (rd_resp.ack) begin
            if (exp_q.size() == 0) begin
                $display("Read response at %0d ns with no read outstanding", $time);
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                chk_cnt++;
                if (rd_resp.data !== e.data) begin
                    $display("Fail at %0d ns: address %h read %h, expected %h",
                             $time, e.addr, rd_resp.data, e.data);
                    err_cnt++;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    // ==================================================
    // Tests
    // ==================================================

    initial begin : run_tests
        int    n;
        addr_t a;
        data_t d;
        rst = 1'b1;
        wr  = '0;
        rd  = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // Clearing time and reads of cleared entries
        start_test();
        wait_rdy(n);
        chk_cnt++;
        if (n != DEPTH) begin
            $display("Fail at %0d ns: rdy rose after %0d cycles, expected %0d",
                     $time, n, DEPTH);
            err_cnt++;
        end
        for (int i = 0; i < 16; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, rand_addr());
        end
        idle_cycle();
        drain_reads();
        finish_test("clear after reset");

        // Single write and read back
        start_test();
        a = rand_addr();
        d = rand_word();
        drive_cycle(1'b1, a, d, 1'b0, '0);
        drive_cycle(1'b0, '0, '0, 1'b1, a);
        idle_cycle();
        drain_reads();
        finish_test("single write and read");

        // Back-to-back writes followed by back-to-back reads
        start_test();
        for (int i = 0; i < BURST_LEN; i++) begin
            drive_cycle(1'b1, rand_addr(), rand_word(), 1'b0, '0);
        end
        for (int i = 0; i < BURST_LEN; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, rand_addr());
        end
        idle_cycle();
        drain_reads();
        finish_test("pipelined burst");

        // Same-edge write and read returns the old word
        start_test();
        a = rand_addr();
        drive_cycle(1'b1, a, rand_word(), 1'b0, '0);
        drive_cycle(1'b1, a, rand_word(), 1'b1, a);
        drive_cycle(1'b0, '0, '0, 1'b1, a);
        idle_cycle();
        drain_reads();
        finish_test("read-first collision");

        // Reset in the middle of a write burst
        start_test();
        for (int i = 0; i < DROP_WR; i++) begin
            drive_cycle(1'b1, rand_addr(), rand_word() | 32'd1, 1'b0, '0);
            if (i == 3) begin
                rst <= 1'b1;
            end
        end
        idle_cycle();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        // Writes and reads during clearing must be dropped
        // Each write lands on an entry the clear has already passed
        for (int i = 0; i < DROP_WR; i++) begin
            drive_cycle(1'b1, addr_t'(i), rand_word() | 32'd1, 1'b1, addr_t'(i));
        end
        idle_cycle();
        wait_rdy(n);
        chk_cnt++;
        if (n + DROP_WR + 1 != DEPTH) begin
            $display("Fail at %0d ns: rdy rose after %0d cycles, expected %0d",
                     $time, n + DROP_WR + 1, DEPTH);
            err_cnt++;
        end
        // Every entry must be zero again
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, addr_t'(i));
        end
        idle_cycle();
        drain_reads();
        finish_test("writes while not ready");

        $display("Tests run: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_mem_ram_sdp

`default_nettype wire
